/* Makefile */
VERILATOR  ?= verilator
TIMESCALE  = --timescale 1ns/100ps
SIM_FLAGS  = --binary --timing --assert $(TIMESCALE)
LINT_FLAGS = --lint-only -Wall --timing $(TIMESCALE)
TOP        = tb_wb_spi
RTL_TOP    = wb_spi_top
FILELIST   = src.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = Simulation finished: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/spi_pkg.sv */
`default_nettype none

package spi_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // command word
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int CMD_WIDTH   = 12;
  localparam int READ_WIDTH  = 8;
  localparam int RD_HDR_BITS = 4;    // rw bit plus the register address.

  typedef union packed {
    struct packed {
      logic                   rw;
      logic [RD_HDR_BITS-2:0] addr;
      logic [READ_WIDTH-1:0]  data;
    } wr;
    struct packed {
      logic                   rw;
      logic [RD_HDR_BITS-2:0] addr;
      logic [READ_WIDTH-1:0]  pad;   // idle while the device turns the bus around.
    } rd;
  } cmd_word_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // spi timing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int SCLK_HALF  = 4;     // clk cycles per sclk half period.
  localparam int TURNAROUND = 8;
  localparam int DIV_W      = 4;
  localparam int BIT_W      = 4;

  localparam int STATE_W = 3;
  localparam logic [STATE_W-1:0] ENG_IDLE     = 3'd0;
  localparam logic [STATE_W-1:0] ENG_WR_SHIFT = 3'd1;
  localparam logic [STATE_W-1:0] ENG_RD_HDR   = 3'd2;
  localparam logic [STATE_W-1:0] ENG_TURN     = 3'd3;
  localparam logic [STATE_W-1:0] ENG_RD_DATA  = 3'd4;
  localparam logic [STATE_W-1:0] ENG_FINISH   = 3'd5;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // wishbone register map
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int WB_ADR_W = 4;
  localparam int WB_DAT_W = 32;

  localparam logic [WB_ADR_W-1:0] REG_CMD    = 4'h0;
  localparam logic [WB_ADR_W-1:0] REG_STATUS = 4'h4;
  localparam logic [WB_ADR_W-1:0] REG_RDATA  = 4'h8;

  localparam int ST_BUSY     = 0;
  localparam int ST_RD_VALID = 1;
  localparam int ST_OVERRUN  = 2;

endpackage

`default_nettype wire

/* hdl/wb_spi_regs.sv */
`default_nettype none

module wb_spi_regs
  import spi_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  wb_cyc,
  input  wire logic                  wb_stb,
  input  wire logic                  wb_we,
  input  wire logic [WB_ADR_W-1:0]   wb_adr,
  input  wire logic [WB_DAT_W-1:0]   wb_dat_w,
  output logic      [WB_DAT_W-1:0]   wb_dat_r,
  output logic                       wb_ack,
  output cmd_word_t                  cmd_in,
  output logic                       cmd_vld,
  input  wire logic                  cmd_rdy,
  input  wire logic                  read_vld,
  input  wire logic [READ_WIDTH-1:0] read_data
);

  logic                  wb_req;
  logic                  wr_cmd;
  logic                  rd_status;
  logic                  rd_rdata;
  logic                  busy;
  logic                  overrun;
  logic                  rd_valid;
  logic [READ_WIDTH-1:0] rdata_q;
  logic [WB_DAT_W-1:0]   status_word;
  logic [WB_DAT_W-1:0]   rd_mux;
  cmd_word_t             cmd_next;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign wb_req    = wb_cyc && wb_stb && !wb_ack;   // one ack per request.
  assign wr_cmd    = wb_req && wb_we && (wb_adr == REG_CMD);
  assign rd_status = wb_req && !wb_we && (wb_adr == REG_STATUS);
  assign rd_rdata  = wb_req && !wb_we && (wb_adr == REG_RDATA);

  always_comb
  begin
    cmd_next = cmd_word_t'(wb_dat_w[CMD_WIDTH-1:0]);
    if (!cmd_next.rd.rw)
      cmd_next.rd.pad = '0;                         // read commands carry no data.
  end

  always_comb
  begin
    status_word              = '0;
    status_word[ST_BUSY]     = busy;
    status_word[ST_RD_VALID] = rd_valid;
    status_word[ST_OVERRUN]  = overrun;
  end

  always_comb
  begin
    case (wb_adr)
      REG_CMD:    rd_mux = WB_DAT_W'(cmd_in);
      REG_STATUS: rd_mux = status_word;
      REG_RDATA:  rd_mux = WB_DAT_W'(rdata_q);
      default:    rd_mux = '0;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // control flags
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_ack   <= 1'b0;
      cmd_vld  <= 1'b0;
      busy     <= 1'b0;
      overrun  <= 1'b0;
      rd_valid <= 1'b0;
    end
    else
    begin
      wb_ack <= wb_req;

      if (wr_cmd && !busy)
      begin
        busy    <= 1'b1;
        cmd_vld <= 1'b1;
      end
      else if (cmd_vld && cmd_rdy)
        cmd_vld <= 1'b0;                            // engine took it.
      else if (busy && !cmd_vld && cmd_rdy)
        busy <= 1'b0;

      if (wr_cmd && busy)
        overrun <= 1'b1;                            // the command is dropped.
      else if (rd_status)
        overrun <= 1'b0;

      if (read_vld)
        rd_valid <= 1'b1;
      else if (rd_rdata)
        rd_valid <= 1'b0;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // data registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk)
  begin
    if (wr_cmd && !busy)
      cmd_in <= cmd_next;
    if (read_vld)
      rdata_q <= read_data;
    if (wb_req && !wb_we)
      wb_dat_r <= rd_mux;
  end

  a_read_busy: assert property (@(posedge clk) disable iff (!rst_n) read_vld |-> busy);

endmodule

`default_nettype wire

/* hdl/wb_spi_top.sv */
`default_nettype none

module wb_spi_top
  import spi_pkg::*;
(
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                wb_cyc,
  input  wire logic                wb_stb,
  input  wire logic                wb_we,
  input  wire logic [WB_ADR_W-1:0] wb_adr,
  input  wire logic [WB_DAT_W-1:0] wb_dat_w,
  output logic      [WB_DAT_W-1:0] wb_dat_r,
  output logic                     wb_ack,
  output logic                     sclk,
  output logic                     cs_n,
  output logic                     mosi,
  input  wire logic                miso
);

  cmd_word_t             cmd_in;
  logic                  cmd_vld;
  logic                  cmd_rdy;
  logic                  read_vld;
  logic [READ_WIDTH-1:0] read_data;

  wb_spi_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_engine u_engine (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

endmodule

`default_nettype wire

/* spi_engine/spi_engine.sv */
`default_nettype none

module spi_engine
  import spi_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire cmd_word_t             cmd_in,
  input  wire logic                  cmd_vld,
  output logic                       cmd_rdy,
  output logic                       sclk,
  output logic                       cs_n,
  output logic                       mosi,
  input  wire logic                  miso,
  output logic                       read_vld,
  output logic [READ_WIDTH-1:0]      read_data
);

  logic [STATE_W-1:0]    state;
  logic [DIV_W-1:0]      div_cnt;
  logic [BIT_W-1:0]      bit_cnt;
  logic [BIT_W-1:0]      last_bit;
  logic [CMD_WIDTH-1:0]  tx_shift;
  logic [READ_WIDTH-1:0] rx_shift;
  logic                  accept;
  logic                  shifting;
  logic                  rise_pt;
  logic                  bit_end;
  logic                  gap_end;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // handshake and phase timing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign cmd_rdy = (state == ENG_IDLE);
  assign accept  = cmd_vld && cmd_rdy;

  assign shifting = (state == ENG_WR_SHIFT) || (state == ENG_RD_HDR) ||
                    (state == ENG_RD_DATA);

  assign rise_pt = shifting && (div_cnt == DIV_W'(SCLK_HALF - 1));      // sclk goes high here.
  assign bit_end = shifting && (div_cnt == DIV_W'(2 * SCLK_HALF - 1));  // and low again here.
  assign gap_end = (state == ENG_TURN) && (div_cnt == DIV_W'(TURNAROUND - 1));

  always_comb
  begin
    case (state)
      ENG_WR_SHIFT: last_bit = BIT_W'(CMD_WIDTH - 1);
      ENG_RD_HDR:   last_bit = BIT_W'(RD_HDR_BITS - 1);
      default:      last_bit = BIT_W'(READ_WIDTH - 1);
    endcase
  end

  assign read_vld  = (state == ENG_FINISH);   // cs_n is already high here.
  assign read_data = rx_shift;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // state machine and pins
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= ENG_IDLE;
      div_cnt <= '0;
      bit_cnt <= '0;
      sclk    <= 1'b0;
      cs_n    <= 1'b1;
      mosi    <= 1'b0;
    end
    else
    begin
      case (state)
        ENG_IDLE:
        begin
          if (accept)
          begin
            if (cmd_in.wr.rw)
              state <= ENG_WR_SHIFT;
            else
              state <= ENG_RD_HDR;
            cs_n    <= 1'b0;
            mosi    <= cmd_in.wr.rw;            // msb leaves with the cs_n fall.
            div_cnt <= '0;
            bit_cnt <= '0;
          end
        end

        ENG_WR_SHIFT, ENG_RD_HDR, ENG_RD_DATA:
        begin
          div_cnt <= div_cnt + 1'b1;
          if (rise_pt)
            sclk <= 1'b1;
          if (bit_end)
          begin
            sclk    <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (state != ENG_RD_DATA)
              mosi <= tx_shift[CMD_WIDTH-1];    // next bit follows the falling edge.
            if (bit_cnt == last_bit)
            begin
              bit_cnt <= '0;
              mosi    <= 1'b0;
              case (state)
                ENG_WR_SHIFT:
                begin
                  state <= ENG_IDLE;
                  cs_n  <= 1'b1;
                end
                ENG_RD_HDR:
                begin
                  state <= ENG_TURN;            // cs_n stays low through the gap.
                end
                default:
                begin
                  state <= ENG_FINISH;
                  cs_n  <= 1'b1;
                end
              endcase
            end
          end
        end

        ENG_TURN:
        begin
          div_cnt <= div_cnt + 1'b1;
          if (gap_end)
          begin
            state   <= ENG_RD_DATA;
            div_cnt <= '0;
          end
        end

        ENG_FINISH:
        begin
          state <= ENG_IDLE;
        end

        default:
        begin
          state <= ENG_IDLE;
          cs_n  <= 1'b1;
          sclk  <= 1'b0;
        end
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // shift registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk)
  begin
    if (accept)
      tx_shift <= {cmd_in[CMD_WIDTH-2:0], 1'b0};   // msb is already on mosi.
    else if (bit_end)
      tx_shift <= {tx_shift[CMD_WIDTH-2:0], 1'b0};

    if (rise_pt && (state == ENG_RD_DATA))
      rx_shift <= {rx_shift[READ_WIDTH-2:0], miso}; // sampled as sclk rises.
  end

  a_cs_idle: assert property (@(posedge clk) disable iff (!rst_n) cmd_rdy |-> cs_n);

  a_sclk_idle: assert property (@(posedge clk) disable iff (!rst_n) cs_n |-> !sclk);

endmodule

`default_nettype wire

/* src.f */
common/spi_pkg.sv
spi_engine/spi_engine.sv
hdl/wb_spi_regs.sv
hdl/wb_spi_top.sv
test/spi_device_model.sv
test/tb_wb_spi.sv

/* test/spi_device_model.sv */
`default_nettype none

module spi_device_model
  import spi_pkg::*;
(
  input  wire logic sclk,
  input  wire logic cs_n,
  input  wire logic mosi,
  output logic      miso
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [READ_WIDTH-1:0] regs [0:7];
  logic [CMD_WIDTH-1:0]  rx_bits;
  logic [READ_WIDTH-1:0] tx_byte;
  logic                  is_read;
  int                    rx_cnt;

  initial
  begin
    for (int i = 0; i < 8; i++)
      regs[i] = 8'(i * 8'h11) ^ 8'hA5;
    miso    = 1'b0;
    rx_bits = '0;
    tx_byte = '0;
    is_read = 1'b0;
    rx_cnt  = 0;
  end

  always @(negedge cs_n)
  begin
    rx_cnt  = 0;
    rx_bits = '0;
    is_read = 1'b0;
  end

  always @(posedge sclk)
  begin
    if (!cs_n)
    begin
      rx_bits = {rx_bits[CMD_WIDTH-2:0], mosi};   // mode 0 samples on the rising edge.
      rx_cnt++;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read answer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(negedge sclk)
  begin
    if (!cs_n && rx_cnt == RD_HDR_BITS && !rx_bits[RD_HDR_BITS-1])
    begin
      is_read = 1'b1;
      tx_byte = regs[rx_bits[RD_HDR_BITS-2:0]];   // header is complete here.
    end
    if (!cs_n && is_read && rx_cnt >= RD_HDR_BITS && rx_cnt < CMD_WIDTH)
    begin
      miso    = tx_byte[READ_WIDTH-1];
      tx_byte = {tx_byte[READ_WIDTH-2:0], 1'b0};
    end
  end

  always @(posedge cs_n)
  begin
    if (rx_cnt == CMD_WIDTH && rx_bits[CMD_WIDTH-1])
      regs[rx_bits[CMD_WIDTH-2:READ_WIDTH]] = rx_bits[READ_WIDTH-1:0];
    miso = 1'b0;
  end

endmodule

`default_nettype wire

/* test/spi_trace.txt */
# op name addr data: W writes data, R expects data on a read,
# O sends a write while busy that must be dropped. addr and data are hex.
R rd_reset_0 0 a5
R rd_reset_1 1 b4
R rd_reset_2 2 87
R rd_reset_3 3 96
R rd_reset_4 4 e1
R rd_reset_5 5 f0
R rd_reset_6 6 c3
R rd_reset_7 7 d2
W wr_3 3 5a
R rd_after_wr_3 3 5a
R rd_keep_4 4 e1
W wr_7 7 3c
R rd_after_wr_7 7 3c
O ovr_5 5 ff
R rd_after_ovr_5 5 f0
W wr_0 0 81
W wr_0_again 0 7e
R rd_after_wr_0 0 7e
R rd_keep_3 3 5a
W wr_6 6 00
R rd_after_wr_6 6 00

/* test/tb_wb_spi.sv */
`default_nettype none

module tb_wb_spi
  import spi_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int BUS_TIMEOUT = 20;    // cycles to wait for wb_ack.
  localparam int BUSY_POLLS  = 200;   // status reads before giving up.

  logic                clk;
  logic                rst_n;
  logic                wb_cyc;
  logic                wb_stb;
  logic                wb_we;
  logic [WB_ADR_W-1:0] wb_adr;
  logic [WB_DAT_W-1:0] wb_dat_w;
  logic [WB_DAT_W-1:0] wb_dat_r;
  logic                wb_ack;
  logic                sclk;
  logic                cs_n;
  logic                mosi;
  logic                miso;

  int     errors;
  int     test_errors;
  int     tests_run;
  int     tests_failed;
  int     access_count;
  int     ack_count;
  int     sclk_rises;
  int     cs_falls;
  int     cs_rises;
  int     stray_sclk;
  integer seed;
  string  test_name;
  logic [WB_DAT_W-1:0] rdata;

  wb_spi_top uut (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .sclk     (sclk),
    .cs_n     (cs_n),
    .mosi     (mosi),
    .miso     (miso)
  );

  spi_device_model u_dev (
    .sclk (sclk),
    .cs_n (cs_n),
    .mosi (mosi),
    .miso (miso)
  );

  always #2 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pin monitors
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(negedge clk)
  begin
    if (wb_ack)
      ack_count++;   // wb_ack is stable half a cycle after the edge.
  end

  always @(posedge sclk)
  begin
    sclk_rises++;
    if (cs_n)
      stray_sclk++;
  end

  always @(negedge cs_n) cs_falls++;
  always @(posedge cs_n) cs_rises++;

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      $display("[ERROR] %s %s: expected 0x%0h, actual 0x%0h", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic bus_access(input logic we, input logic [WB_ADR_W-1:0] adr,
                            input logic [WB_DAT_W-1:0] wdata,
                            output logic [WB_DAT_W-1:0] data);
    int waited;
    waited   = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    access_count++;
    @(posedge clk);
    #0.5;
    while (!wb_ack && waited < BUS_TIMEOUT)
    begin
      @(posedge clk);
      #0.5;
      waited++;
    end
    if (!wb_ack)
    begin
      $display("%s: the bus access to address 0x%0h was never acknowledged", test_name, adr);
      test_errors++;
    end
    data   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] data);
    logic [WB_DAT_W-1:0] unused;
    bus_access(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [WB_ADR_W-1:0] adr, output logic [WB_DAT_W-1:0] data);
    bus_access(1'b0, adr, '0, data);
  endtask

  task automatic wait_idle();
    logic [WB_DAT_W-1:0] st;
    int polls;
    polls = 0;
    wb_read(REG_STATUS, st);
    while (st[ST_BUSY] && polls < BUSY_POLLS)
    begin
      wb_read(REG_STATUS, st);
      polls++;
    end
    if (st[ST_BUSY])
    begin
      $display("%s: the SPI transaction did not finish in time", test_name);
      test_errors++;
    end
  endtask

  task automatic run_command(input cmd_word_t cmd);
    sclk_rises = 0;
    cs_falls   = 0;
    cs_rises   = 0;
    stray_sclk = 0;
    wb_write(REG_CMD, WB_DAT_W'(cmd));
    wait_idle();
    check_value("sclk rises", cmd.wr.rw ? CMD_WIDTH : RD_HDR_BITS + READ_WIDTH, sclk_rises);
    check_value("cs_n falls", 1, cs_falls);   // one fall and one rise keep cs_n low throughout.
    check_value("cs_n rises", 1, cs_rises);
    check_value("sclk rises with cs_n high", 0, stray_sclk);
  endtask

  task automatic read_test(input logic [2:0] addr, input logic [7:0] expected);
    cmd_word_t           cmd;
    logic [WB_DAT_W-1:0] r;
    cmd.rd.rw   = 1'b0;
    cmd.rd.addr = addr;
    cmd.rd.pad  = '0;
    run_command(cmd);
    wb_read(REG_STATUS, r);
    check_value("rd_valid before RDATA", 1, r[ST_RD_VALID]);
    wb_read(REG_RDATA, r);
    check_value("read data", expected, r[READ_WIDTH-1:0]);
    wb_read(REG_STATUS, r);
    check_value("rd_valid after RDATA", 0, r[ST_RD_VALID]);
  endtask

  task automatic overrun_test(input logic [2:0] addr, input logic [7:0] data);
    cmd_word_t           cmd;
    logic [WB_DAT_W-1:0] r;
    cmd.rd.rw   = 1'b0;
    cmd.rd.addr = addr;
    cmd.rd.pad  = '0;
    wb_write(REG_CMD, WB_DAT_W'(cmd));
    wb_read(REG_STATUS, r);
    check_value("busy during probe", 1, r[ST_BUSY]);
    cmd.wr.rw   = 1'b1;
    cmd.wr.data = data;
    wb_write(REG_CMD, WB_DAT_W'(cmd));   // lands while the read is still shifting.
    wb_read(REG_STATUS, r);
    check_value("overrun set", 1, r[ST_OVERRUN]);
    wb_read(REG_STATUS, r);
    check_value("overrun cleared", 0, r[ST_OVERRUN]);
    wait_idle();
    wb_read(REG_RDATA, r);
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    errors += test_errors;
    if (test_errors == 0)
      $display("test %s passed", test_name);
    else
    begin
      tests_failed++;
      $display("test %s failed with %0d errors", test_name, test_errors);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // trace replay
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic replay_trace();
    int          fd;
    int          n;
    int          gap;
    string       line;
    string       op;
    string       name;
    logic [31:0] addr;
    logic [31:0] val;
    cmd_word_t   cmd;
    fd = $fopen("test/spi_trace.txt", "r");
    if (fd == 0)
    begin
      $display("the trace file test/spi_trace.txt could not be opened");
      errors++;
      return;
    end
    while (!$feof(fd))
    begin
      line = "";
      n    = $fgets(line, fd);
      if (n == 0 || line.len() < 2 || line.substr(0, 0) == "#")
        continue;
      n = $sscanf(line, "%s %s %h %h", op, name, addr, val);
      if (n != 4)
      begin
        $display("a trace line could not be parsed: %s", line);
        errors++;
        continue;
      end
      gap = $unsigned($random(seed)) % 6;
      repeat (gap)
      begin
        @(posedge clk);
        #0.5;
      end
      start_test(name);
      case (op)
        "W":
        begin
          cmd.wr.rw   = 1'b1;
          cmd.wr.addr = addr[2:0];
          cmd.wr.data = val[7:0];
          run_command(cmd);
        end
        "R": read_test(addr[2:0], val[7:0]);
        "O": overrun_test(addr[2:0], val[7:0]);
        default:
        begin
          $display("%s: unknown op letter %s in the trace", name, op);
          test_errors++;
        end
      endcase
      finish_test();
    end
    $fclose(fd);
  endtask

  initial
  begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_dat_w     = '0;
    seed         = 29;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    access_count = 0;
    ack_count    = 0;
    repeat (10) @(posedge clk);
    #0.5;
    rst_n = 1'b1;

    start_test("reset");
    check_value("cs_n", 1, cs_n);
    check_value("sclk", 0, sclk);
    check_value("mosi", 0, mosi);
    wb_read(REG_STATUS, rdata);
    check_value("status", 0, rdata);
    finish_test();

    replay_trace();

    repeat (2) @(posedge clk);
    start_test("bus_acks");
    check_value("ack count", access_count, ack_count);
    finish_test();

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
